/* files.f */
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/instr_decoder.sv
hw/pipe_slot.sv
hw/commit_unit.sv
hw/ctrl_pipe_top.sv
testbench/ctrl_pipe_assertions.sv
testbench/tb_ctrl_pipe.sv

/* hw/commit_unit.sv */
`timescale 1ns/1ps

module commit_unit
	import ctrl_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,

	input  logic  in_valid,
	output logic  in_ready,
	input  ctrl_t in_ctrl,

	output logic  out_valid,
	input  logic  out_ready,
	output ctrl_t out_ctrl,

	output logic  flush
);

	retire_t ret;
	logic    is_exc;
	logic    retire_fire;

	assign is_exc = (in_ctrl.exc != EXC_NONE);

	// nothing moves while the flush is being applied
	assign in_ready = out_ready & ~flush;

	always_comb begin
		ret.valid = in_valid & ~flush;
		ret.ctrl  = in_ctrl;
		if (is_exc) begin
			// an excepting word must not change architectural state
			ret.ctrl.reg_write_en = 1'b0;
			ret.ctrl.mem_write_en = 1'b0;
			ret.ctrl.hilo_wen     = 1'b0;
			ret.ctrl.cp0_wen      = 1'b0;
		end
	end

	assign out_valid   = ret.valid;
	assign out_ctrl    = ret.ctrl;
	assign retire_fire = ret.valid & out_ready;

	// one-cycle pulse after an excepting word retires
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			flush <= 1'b0;
		else
			flush <= retire_fire & is_exc;  // ret.valid is low during flush, so no repeat
	end

endmodule

/* hw/ctrl_pipe_top.sv */
`timescale 1ns/1ps

module ctrl_pipe_top
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,

	input  logic   in_valid,
	output logic   in_ready,
	input  instr_t instr,

	output logic   out_valid,
	input  logic   out_ready,
	output ctrl_t  out_ctrl,

	output logic   flush
);

	// index k feeds slot k, index N_STAGES feeds the commit unit
	logic  s_valid [0:N_STAGES];
	logic  s_ready [0:N_STAGES];
	ctrl_t s_ctrl  [0:N_STAGES];

	instr_decoder i_instr_decoder (
		.instr (instr),
		.ctrl  (s_ctrl[0])
	);

	// no new word enters during the flush cycle
	assign s_valid[0] = in_valid & ~flush;
	assign in_ready   = s_ready[0] & ~flush;

	for (genvar k = 0; k < N_STAGES; k++) begin : g_slot
		pipe_slot i_pipe_slot (
			.clk       (clk),
			.rst_n     (rst_n),
			.flush     (flush),
			.in_valid  (s_valid[k]),
			.in_ready  (s_ready[k]),
			.in_ctrl   (s_ctrl[k]),
			.out_valid (s_valid[k+1]),
			.out_ready (s_ready[k+1]),
			.out_ctrl  (s_ctrl[k+1])
		);
	end

	commit_unit i_commit_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (s_valid[N_STAGES]),
		.in_ready  (s_ready[N_STAGES]),
		.in_ctrl   (s_ctrl[N_STAGES]),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_ctrl  (out_ctrl),
		.flush     (flush)
	);

endmodule

/* hw/ctrl_pkg.sv */
package ctrl_pkg;

	// number of pipeline slots after decode (ex, mem, wb)
	localparam int N_STAGES = 3;

	// destination register select
	typedef logic [1:0] reg_sel_t;

	localparam reg_sel_t SEL_RD = 2'd0;
	localparam reg_sel_t SEL_RT = 2'd1;
	localparam reg_sel_t SEL_RA = 2'd2;  // link register $31

	typedef enum logic [2:0] {
		EXC_NONE    = 3'd0,
		EXC_RI      = 3'd1,  // reserved instruction
		EXC_BREAK   = 3'd2,
		EXC_SYSCALL = 3'd3,
		EXC_ERET    = 3'd4
	} exc_cause_t;

	// one decoded instruction as it flows down the pipe
	typedef struct packed {
		logic       reg_write_en;
		reg_sel_t   reg_dst;
		logic       alu_imm_sel;   // alu operand b from the immediate
		logic       sign_ext;
		logic       mem_read_en;
		logic       mem_write_en;
		logic       mem_to_reg;
		logic       hilo_wen;
		logic       hilo_to_reg;
		logic       is_div;
		logic       cp0_wen;
		logic       cp0_to_reg;
		exc_cause_t exc;
	} ctrl_t;

	// what leaves the commit stage
	typedef struct packed {
		logic  valid;
		ctrl_t ctrl;
	} retire_t;

endpackage

/* hw/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  instr_t instr,
	output ctrl_t  ctrl
);

	opcode_t    op;
	funct_t     fn;
	reg_field_t rs;
	reg_field_t rt;

	logic is_rtype;
	logic ri;
	logic is_break;
	logic is_syscall;
	logic is_eret;

	assign op = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign fn = instr[5:0];

	assign is_rtype   = (op == OP_RTYPE);
	assign is_break   = is_rtype && (fn == FN_BREAK);
	assign is_syscall = is_rtype && (fn == FN_SYSCALL);
	assign is_eret    = (instr == {OP_COP0, ERET_LOW});

	always_comb begin
		ctrl = '0;
		ri   = 1'b0;

		case (op)
			OP_RTYPE: begin
				case (fn)
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
					FN_AND, FN_OR, FN_XOR, FN_NOR,
					FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
					FN_MFHI, FN_MFLO: begin
						ctrl.reg_write_en = 1'b1;
						ctrl.reg_dst      = SEL_RD;
					end
					// no register result
					FN_JR, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
					FN_MTHI, FN_MTLO, FN_SYSCALL, FN_BREAK: begin
						ctrl.reg_write_en = 1'b0;
					end
					FN_JALR: begin
						ctrl.reg_write_en = 1'b1;
						ctrl.reg_dst      = SEL_RA;  // always links to $31
					end
					default: begin
						ri                = 1'b1;
						ctrl.reg_write_en = 1'b1;  // fallback as for alu ops
						ctrl.reg_dst      = SEL_RD;
					end
				endcase
			end

			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.reg_dst      = SEL_RT;
				ctrl.alu_imm_sel  = 1'b1;
			end

			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_J: ;  // nothing written

			OP_REGIMM: begin
				case (rt[4:1])
					4'b1000: begin  // bltzal, bgezal
						ctrl.reg_write_en = 1'b1;
						ctrl.reg_dst      = SEL_RA;
					end
					4'b0000: ;  // bltz, bgez
					default: ri = 1'b1;
				endcase
			end

			OP_JAL: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.reg_dst      = SEL_RA;
			end

			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.reg_dst      = SEL_RT;
				ctrl.alu_imm_sel  = 1'b1;
				ctrl.mem_read_en  = 1'b1;
				ctrl.mem_to_reg   = 1'b1;
			end

			OP_SB, OP_SH, OP_SW: begin
				ctrl.alu_imm_sel  = 1'b1;  // address = base + offset
				ctrl.mem_write_en = 1'b1;
			end

			OP_COP0: begin
				case (rs)
					RS_MTC0: ;
					RS_MFC0: begin
						ctrl.reg_write_en = 1'b1;
						ctrl.reg_dst      = SEL_RT;
					end
					default: ri = (instr[25:0] != ERET_LOW);
				endcase
			end

			default: ri = 1'b1;
		endcase

		// flags that do not depend on the class above
		ctrl.sign_ext    = !(op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI});
		ctrl.hilo_wen    = is_rtype &&
		                   (fn inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MTHI, FN_MTLO});
		ctrl.hilo_to_reg = is_rtype && (fn inside {FN_MFHI, FN_MFLO});
		ctrl.is_div      = is_rtype && (fn inside {FN_DIV, FN_DIVU});
		ctrl.cp0_wen     = (op == OP_COP0) && (rs == RS_MTC0);
		ctrl.cp0_to_reg  = (op == OP_COP0) && (rs == RS_MFC0);

		// ri wins over the rest
		if (ri)
			ctrl.exc = EXC_RI;
		else if (is_break)
			ctrl.exc = EXC_BREAK;
		else if (is_syscall)
			ctrl.exc = EXC_SYSCALL;
		else if (is_eret)
			ctrl.exc = EXC_ERET;
		else
			ctrl.exc = EXC_NONE;
	end

endmodule

/* hw/isa_pkg.sv */
package isa_pkg;

	// instruction field types
	typedef logic [31:0] instr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  reg_field_t;   // rs / rt

	// primary opcodes
	localparam opcode_t OP_RTYPE  = 6'b000000;
	localparam opcode_t OP_REGIMM = 6'b000001;  // bltz/bgez and the linking forms
	localparam opcode_t OP_J      = 6'b000010;
	localparam opcode_t OP_JAL    = 6'b000011;
	localparam opcode_t OP_BEQ    = 6'b000100;
	localparam opcode_t OP_BNE    = 6'b000101;
	localparam opcode_t OP_BLEZ   = 6'b000110;
	localparam opcode_t OP_BGTZ   = 6'b000111;
	localparam opcode_t OP_ADDI   = 6'b001000;
	localparam opcode_t OP_ADDIU  = 6'b001001;
	localparam opcode_t OP_SLTI   = 6'b001010;
	localparam opcode_t OP_SLTIU  = 6'b001011;
	localparam opcode_t OP_ANDI   = 6'b001100;
	localparam opcode_t OP_ORI    = 6'b001101;
	localparam opcode_t OP_XORI   = 6'b001110;
	localparam opcode_t OP_LUI    = 6'b001111;
	localparam opcode_t OP_COP0   = 6'b010000;  // mfc0, mtc0, eret
	localparam opcode_t OP_LB     = 6'b100000;
	localparam opcode_t OP_LH     = 6'b100001;
	localparam opcode_t OP_LW     = 6'b100011;
	localparam opcode_t OP_LBU    = 6'b100100;
	localparam opcode_t OP_LHU    = 6'b100101;
	localparam opcode_t OP_SB     = 6'b101000;
	localparam opcode_t OP_SH     = 6'b101001;
	localparam opcode_t OP_SW     = 6'b101011;

	// R-type function codes
	localparam funct_t FN_SLL     = 6'b000000;
	localparam funct_t FN_SRL     = 6'b000010;
	localparam funct_t FN_SRA     = 6'b000011;
	localparam funct_t FN_SLLV    = 6'b000100;
	localparam funct_t FN_SRLV    = 6'b000110;
	localparam funct_t FN_SRAV    = 6'b000111;
	localparam funct_t FN_JR      = 6'b001000;
	localparam funct_t FN_JALR    = 6'b001001;
	localparam funct_t FN_SYSCALL = 6'b001100;
	localparam funct_t FN_BREAK   = 6'b001101;
	localparam funct_t FN_MFHI    = 6'b010000;
	localparam funct_t FN_MTHI    = 6'b010001;
	localparam funct_t FN_MFLO    = 6'b010010;
	localparam funct_t FN_MTLO    = 6'b010011;
	localparam funct_t FN_MULT    = 6'b011000;
	localparam funct_t FN_MULTU   = 6'b011001;
	localparam funct_t FN_DIV     = 6'b011010;
	localparam funct_t FN_DIVU    = 6'b011011;
	localparam funct_t FN_ADD     = 6'b100000;
	localparam funct_t FN_ADDU    = 6'b100001;
	localparam funct_t FN_SUB     = 6'b100010;
	localparam funct_t FN_SUBU    = 6'b100011;
	localparam funct_t FN_AND     = 6'b100100;
	localparam funct_t FN_OR      = 6'b100101;
	localparam funct_t FN_XOR     = 6'b100110;
	localparam funct_t FN_NOR     = 6'b100111;
	localparam funct_t FN_SLT     = 6'b101010;
	localparam funct_t FN_SLTU    = 6'b101011;

	// cop0 rs field
	localparam reg_field_t RS_MFC0 = 5'b00000;
	localparam reg_field_t RS_MTC0 = 5'b00100;

	// eret is one exact word, co bit set and funct 011000
	localparam logic [25:0] ERET_LOW = 26'h200_0018;

endpackage

/* hw/pipe_slot.sv */
`timescale 1ns/1ps

module pipe_slot
	import ctrl_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  flush,

	input  logic  in_valid,
	output logic  in_ready,
	input  ctrl_t in_ctrl,

	output logic  out_valid,
	input  logic  out_ready,
	output ctrl_t out_ctrl
);

	logic  valid_q;
	ctrl_t ctrl_q;

	// room when empty or when the held word leaves this cycle
	assign in_ready  = ~valid_q | out_ready;
	assign out_valid = valid_q;
	assign out_ctrl  = ctrl_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (flush) begin
			valid_q <= 1'b0;  // flush beats a new word
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			ctrl_q <= in_ctrl;
	end

endmodule

/* run_sim.sh */
#!/bin/bash
# build and run the control pipeline testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ctrl_pipe \
	-f files.f \
	-o sim_ctrl_pipe

./obj_dir/sim_ctrl_pipe 2>&1 | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation passed"

/* testbench/ctrl_pipe_assertions.sv */
`timescale 1ns/1ps

module ctrl_pipe_assertions
	import ctrl_pkg::*;
(
	input logic  clk,
	input logic  rst_n,
	input logic  in_ready,
	input logic  out_valid,
	input logic  out_ready,
	input ctrl_t out_ctrl,
	input logic  flush
);

	a_flush_single: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !flush)
		else $error("flush stayed high for more than one cycle");

	// retire port holds its word until taken
	a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_ctrl))
		else $error("out_valid or out_ctrl changed while out_ready was low");

	a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		flush |-> !in_ready && !out_valid)
		else $error("handshake open during the flush cycle");

	a_exc_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && out_ctrl.exc != EXC_NONE |-> !(out_ctrl.reg_write_en ||
		out_ctrl.mem_write_en || out_ctrl.hilo_wen || out_ctrl.cp0_wen))
		else $error("excepting word retired with a write enable set");

	// refill after a flush needs a full trip through the slots
	for (genvar d = 1; d <= N_STAGES; d++) begin : g_refill
		a_refill: assert property (@(posedge clk) disable iff (!rst_n)
			out_valid |-> !$past(flush, d))
			else $error("word retired too soon after a flush");
	end

endmodule

bind ctrl_pipe_top ctrl_pipe_assertions i_ctrl_pipe_assertions (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_ctrl  (out_ctrl),
	.flush     (flush)
);

/* testbench/tb_ctrl_pipe.sv */
`timescale 1ns/1ps

module tb_ctrl_pipe
	import isa_pkg::*;
	import ctrl_pkg::*;
();

	localparam int CLK_PERIOD   = 4;
	localparam int SEED         = 25317;
	localparam int N_LEGAL      = 200;
	localparam int N_RESERVED   = 60;
	localparam int N_EXC        = 120;
	localparam int N_BP         = 200;
	localparam int N_TOTAL      = N_LEGAL + N_RESERVED + N_EXC + N_BP;
	localparam int WATCHDOG_NS  = (N_TOTAL * 20 + 100) * CLK_PERIOD;  // extra for reset and drains
	localparam int DRAIN_LIMIT  = 200;  // cycles to empty the pipe at the end of a test
	localparam int MIX_LEGAL    = 0;
	localparam int MIX_RESERVED = 1;
	localparam int MIX_EXC      = 2;

	logic   clk = 1'b0;
	logic   rst_n;
	logic   in_valid;
	logic   in_ready;
	instr_t instr;
	logic   out_valid;
	logic   out_ready;
	ctrl_t  out_ctrl;
	logic   flush;

	ctrl_t       exp_q [$];  // in-flight words, oldest first
	ctrl_t       exp_word;
	int unsigned lcg_state = SEED;
	int          n_errors = 0;
	int          n_checks = 0;
	int          n_tests = 0;
	int          n_failed_tests = 0;
	int          n_accepted = 0;
	int          n_retired = 0;
	int          n_discarded = 0;
	int          n_flushes = 0;
	int          n_exc_retired = 0;
	int          n_full_cycles = 0;
	int          err0;
	int          flush0;
	int          exc0;
	int          disc0;
	int          full0;

	funct_t legal_fn [26] = '{
		FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU, FN_AND, FN_OR, FN_XOR, FN_NOR,
		FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR, FN_JALR,
		FN_MFHI, FN_MTHI, FN_MFLO, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU
	};
	opcode_t legal_op [22] = '{
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
		OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW,
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_J, OP_JAL
	};

	ctrl_pipe_top i_ctrl_pipe_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.instr     (instr),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_ctrl  (out_ctrl),
		.flush     (flush)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state ^ (lcg_state >> 15);  // fold high bits into the weak low ones
	endfunction

	function automatic logic chance(input int unsigned pct);
		return (next_rand() % 100) < pct;
	endfunction

	// expected control word, write enables already suppressed for exceptions
	function automatic ctrl_t model_decode(input instr_t w);
		ctrl_t      e;
		opcode_t    op;
		funct_t     fn;
		reg_field_t rs;
		reg_field_t rt;
		logic       known;
		op         = w[31:26];
		fn         = w[5:0];
		rs         = w[25:21];
		rt         = w[20:16];
		e          = '0;
		known      = 1'b1;
		e.sign_ext = 1'b1;
		e.exc      = EXC_NONE;
		if (op == OP_RTYPE) begin
			if (fn inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MTHI, FN_MTLO}) begin
				e.hilo_wen = 1'b1;
				e.is_div   = fn inside {FN_DIV, FN_DIVU};
			end else if (fn == FN_JALR) begin
				e.reg_write_en = 1'b1;
				e.reg_dst      = SEL_RA;
			end else if (fn == FN_SYSCALL) begin
				e.exc = EXC_SYSCALL;
			end else if (fn == FN_BREAK) begin
				e.exc = EXC_BREAK;
			end else if (fn != FN_JR) begin
				// alu, shifts, mfhi/mflo; unknown functs fall back to an rd write too
				e.reg_write_en = 1'b1;
				e.reg_dst      = SEL_RD;
				e.hilo_to_reg  = fn inside {FN_MFHI, FN_MFLO};
				known = fn inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU, FN_AND,
				                   FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SRL, FN_SRA, FN_SLLV,
				                   FN_SRLV, FN_SRAV, FN_MFHI, FN_MFLO};
			end
		end else if (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
		                        OP_LUI, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW}) begin
			e.reg_write_en = 1'b1;
			e.reg_dst      = SEL_RT;
			e.alu_imm_sel  = 1'b1;
			e.sign_ext     = !(op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI});  // zero-extended
			e.mem_read_en  = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
			e.mem_to_reg   = e.mem_read_en;
		end else if (op inside {OP_SB, OP_SH, OP_SW}) begin
			e.alu_imm_sel  = 1'b1;
			e.mem_write_en = 1'b1;
		end else if (op == OP_JAL || (op == OP_REGIMM && rt inside {5'd16, 5'd17})) begin
			e.reg_write_en = 1'b1;  // link to $31
			e.reg_dst      = SEL_RA;
		end else if (op == OP_REGIMM) begin
			known = rt inside {5'd0, 5'd1};  // bltz, bgez
		end else if (op == OP_COP0) begin
			if (rs == RS_MFC0) begin
				e.reg_write_en = 1'b1;
				e.reg_dst      = SEL_RT;
				e.cp0_to_reg   = 1'b1;
			end else if (rs == RS_MTC0) begin
				e.cp0_wen = 1'b1;
			end else if (w[25:0] == ERET_LOW) begin
				e.exc = EXC_ERET;
			end else begin
				known = 1'b0;
			end
		end else begin
			known = op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_J};
		end
		if (!known)
			e.exc = EXC_RI;
		if (e.exc != EXC_NONE) begin
			e.reg_write_en = 1'b0;
			e.mem_write_en = 1'b0;
			e.hilo_wen     = 1'b0;
			e.cp0_wen      = 1'b0;
		end
		return e;
	endfunction

	function automatic instr_t pick_legal();
		logic [31:0] rnd;
		instr_t      word;
		rnd = next_rand();
		case (next_rand() % 7)
			0, 1: word = {OP_RTYPE, rnd[25:6], legal_fn[next_rand() % 18]};
			2: word = {OP_RTYPE, rnd[25:6], legal_fn[18 + next_rand() % 8]};  // hi/lo group
			3, 4: word = {legal_op[next_rand() % 22], rnd[25:0]};
			5: word = {OP_REGIMM, rnd[25:21], rnd[20], 3'b000, rnd[16], rnd[15:0]};
			default: word = {OP_COP0, rnd[31] ? RS_MFC0 : RS_MTC0, rnd[20:0]};
		endcase
		return word;
	endfunction

	function automatic instr_t pick_reserved();
		logic [31:0] rnd;
		logic [25:0] low;
		instr_t      word;
		rnd = next_rand();
		case (next_rand() % 4)
			0: word = {rnd[31] ? {3'b011, rnd[2:0]} : {2'b11, rnd[3:0]}, rnd[25:0]};
			1: word = {OP_RTYPE, rnd[25:6], rnd[31] ? {4'b0111, rnd[1:0]} : {2'b11, rnd[3:0]}};
			2: word = {OP_REGIMM, rnd[25:21], rnd[30], 1'b1, rnd[19:17], rnd[15:0]};  // rt 8..15, 24..31
			default: begin
				low  = ERET_LOW ^ (26'd1 << (next_rand() % 21));  // eret with one bit off
				word = rnd[31] ? {OP_COP0, 3'b010, rnd[22:0]} : {OP_COP0, low};
			end
		endcase
		return word;
	endfunction

	function automatic instr_t pick_instr(input int mix);
		logic [31:0] rnd;
		rnd = next_rand();
		if (mix == MIX_RESERVED)
			return pick_reserved();
		if (mix == MIX_EXC && chance(15)) begin
			case (rnd % 3)
				0: return {OP_RTYPE, rnd[25:6], FN_BREAK};
				1: return {OP_RTYPE, rnd[25:6], FN_SYSCALL};
				default: return {OP_COP0, ERET_LOW};
			endcase
		end
		return pick_legal();
	endfunction

	// scoreboard, sampled mid-cycle where every signal is settled
	always @(negedge clk) begin
		if (rst_n) begin
			if (!flush) begin
				n_checks++;
				assert (in_ready == !(exp_q.size() == N_STAGES && !out_ready)) else begin
					$display("FAILED at %0t ns: in_ready %0b with %0d words in flight", $time,
					         in_ready, exp_q.size());
					n_errors++;
				end
				if (!in_ready)
					n_full_cycles++;
			end
			if (out_valid && out_ready) begin
				n_retired++;
				assert (exp_q.size() != 0) else begin
					$display("%0t ns: a word retired although none was expected", $time);
					n_errors++;
				end
				if (exp_q.size() != 0) begin
					exp_word = exp_q.pop_front();
					n_checks++;
					if (exp_word.exc != EXC_NONE)
						n_exc_retired++;
					assert (out_ctrl === exp_word) else begin
						$display("FAILED at %0t ns: out_ctrl %h, expected %h", $time, out_ctrl,
						         exp_word);
						n_errors++;
					end
				end
			end
			if (in_valid && in_ready) begin
				exp_q.push_back(model_decode(instr));
				n_accepted++;
			end
			if (flush) begin
				n_flushes++;
				n_discarded += exp_q.size();
				exp_q.delete();
			end
		end
	end

	task automatic send_words(input int count, input int mix, input bit stall_out);
		int   sent;
		logic taken;
		sent = 0;
		while (sent < count) begin
			if (!in_valid && chance(70)) begin
				instr    = pick_instr(mix);
				in_valid = 1'b1;
			end
			out_ready = stall_out ? chance(50) : 1'b1;
			@(negedge clk);
			taken = in_valid && in_ready;
			@(posedge clk);
			#1;
			if (taken) begin
				sent++;
				in_valid = 1'b0;
			end
		end
	endtask

	// wait until nothing is in flight, then a few idle cycles for strays
	task automatic drain(input bit stall_out);
		int idle;
		int waited;
		idle   = 0;
		waited = 0;
		while (idle < 2 * N_STAGES + 2 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			#1;
			out_ready = stall_out ? chance(50) : 1'b1;
			idle = (exp_q.size() == 0 && !flush) ? idle + 1 : 0;
			waited++;
		end
		out_ready = 1'b1;
	endtask

	task automatic begin_test();
		err0   = n_errors;
		flush0 = n_flushes;
		exc0   = n_exc_retired;
		disc0  = n_discarded;
		full0  = n_full_cycles;
	endtask

	task automatic run_stream(input int count, input int mix, input bit stall_out);
		int acc0;
		int out0;
		acc0 = n_accepted;
		out0 = n_retired + n_discarded;
		send_words(count, mix, stall_out);
		drain(stall_out);
		assert (n_retired + n_discarded - out0 == n_accepted - acc0) else begin
			$display("%0t ns: %0d words accepted but %0d retired or flushed", $time,
			         n_accepted - acc0, n_retired + n_discarded - out0);
			n_errors++;
		end
		assert (n_flushes - flush0 == n_exc_retired - exc0) else begin
			$display("%0t ns: flush pulses do not match the excepting words retired", $time);
			n_errors++;
		end
	endtask

	task automatic end_test(input string name);
		n_tests++;
		if (n_errors == err0) begin
			$display("test %0d %s: passed", n_tests, name);
		end else begin
			n_failed_tests++;
			$display("test %0d %s: failed with %0d errors", n_tests, name, n_errors - err0);
		end
	endtask

	initial begin
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		instr     = '0;
		out_ready = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		begin_test();
		n_checks++;
		assert (!out_valid && !flush && in_ready) else begin
			$display("FAILED at %0t ns: after reset out_valid %0b flush %0b in_ready %0b", $time,
			         out_valid, flush, in_ready);
			n_errors++;
		end
		end_test("reset state");

		begin_test();
		run_stream(N_LEGAL, MIX_LEGAL, 1'b0);
		end_test("legal decode");

		begin_test();
		run_stream(N_RESERVED, MIX_RESERVED, 1'b0);
		end_test("reserved encodings");

		begin_test();
		run_stream(N_EXC, MIX_EXC, 1'b0);
		assert (n_flushes > flush0 && n_discarded > disc0) else begin
			$display("%0t ns: no flush discarded any younger word", $time);
			n_errors++;
		end
		end_test("exceptions and flush");

		begin_test();
		run_stream(N_BP, MIX_LEGAL, 1'b1);
		assert (n_full_cycles > full0) else begin
			$display("%0t ns: in_ready never fell under back-pressure", $time);
			n_errors++;
		end
		end_test("back-pressure");

		$display("tests %0d, failed %0d, checks %0d, errors %0d", n_tests, n_failed_tests,
		         n_checks, n_errors);
		if (n_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("run timed out after %0d ns with %0d words still expected", WATCHDOG_NS,
		         exp_q.size());
		$display("** FAIL **");
		$finish;
	end

endmodule
